//--- Makefile
# Verilator build and run for the line doubler testbench

TOP             ?= tb_dcxplus
SEED            ?= 27
LOG             ?= sim.log
FILELIST        ?= tb.f
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert --timescale 1ns/1ps -j 0
RUN_FLAGS       ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps -f $(FILELIST) \
		--top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dc_reset_hold.sv
`include "dcxplus_config.svh"

module dc_reset_hold (
    input  logic reset_clock,
    input  logic reset_dc,
    output logic dc_nreset_low
);

    localparam int CNT_W = $clog2(`DC_RESET_CYCLES);

    // count reaches the last value on the final hold edge
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`DC_RESET_CYCLES - 1);

    logic [CNT_W-1:0] hold_cnt;

    //////////////////////////////
    // console reset hold

    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            hold_cnt      <= '0;
            dc_nreset_low <= 1'b1;
        end else if (dc_nreset_low) begin
            if (hold_cnt == HOLD_LAST) begin
                // console released, counter parks here
                dc_nreset_low <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

//--- dc_video_input.sv
`include "dcxplus_config.svh"

module dc_video_input import dcxplus_pkg::*; (
    input  logic        reset_clock,
    input  logic        reset_dc,
    input  logic        hsync_n,
    input  logic        vsync_n,
    input  logic [11:0] dc_data,
    output logic        pixel_valid,
    output rgb_pixel_t  pixel,
    output line_coord_t pixel_x,
    output line_coord_t pixel_y,
    output logic        line_done,
    output line_coord_t line_y
);

    logic        hsync_n_q;
    logic        vsync_n_q;
    logic        hsync_fall;
    logic        vsync_fall;
    logic        phase;
    logic [7:0]  red_hold;
    logic [3:0]  green_hi_hold;
    line_coord_t x_count;
    line_coord_t y_count;

    // previous sync levels, edges found against the live input
    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            hsync_n_q <= 1'b0;
            vsync_n_q <= 1'b0;
        end else begin
            hsync_n_q <= hsync_n;
            vsync_n_q <= vsync_n;
        end
    end

    assign hsync_fall = hsync_n_q & ~hsync_n;
    assign vsync_fall = vsync_n_q & ~vsync_n;

    //////////////////////////////
    // two-phase pixel capture

    // phase 0 holds red and upper green
    always_ff @(posedge reset_clock) begin
        if (hsync_n && !phase) begin
            red_hold      <= dc_data[11:4];
            green_hi_hold <= dc_data[3:0];
        end
        if (hsync_n && phase) begin
            pixel.red   <= red_hold;
            pixel.green <= {green_hi_hold, dc_data[11:8]};
            pixel.blue  <= dc_data[7:0];
        end
    end

    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            phase       <= 1'b0;
            pixel_valid <= 1'b0;
            pixel_x     <= '0;
            pixel_y     <= '0;
            x_count     <= '0;
        end else begin
            pixel_valid <= 1'b0;
            if (!hsync_n) begin
                // blanking keeps the phase aligned to the line start
                phase <= 1'b0;
            end else begin
                phase <= ~phase;
                if (phase) begin
                    pixel_valid <= 1'b1;
                    pixel_x     <= x_count;
                    pixel_y     <= y_count;
                    // stop at the stored width so x never wraps back in range
                    if (x_count != line_coord_t'(`LINE_WIDTH)) begin
                        x_count <= x_count + line_coord_t'(1);
                    end
                end
            end
            if (hsync_fall) begin
                x_count <= '0;
            end
        end
    end

    //////////////////////////////
    // line and frame counting

    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            line_done <= 1'b0;
            line_y    <= '0;
            y_count   <= '0;
        end else begin
            line_done <= hsync_fall;
            if (hsync_fall) begin
                line_y  <= y_count;
                y_count <= y_count + line_coord_t'(1);
            end
            // frame start wins over a same-cycle line end
            if (vsync_fall) begin
                y_count <= '0;
            end
        end
    end

endmodule

//--- dcxplus_asserts.sv
`include "dcxplus_config.svh"

module dcxplus_asserts (
    input logic reset_clock,
    input logic reset_dc,
    input logic hsync,
    input logic de
);

    timeunit 1ns;
    timeprecision 100ps;

    int         fail_count = 0;
    logic [7:0] de_run;
    logic [7:0] hsync_run;

    // length of the current high run
    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            de_run    <= '0;
            hsync_run <= '0;
        end else begin
            de_run    <= de ? de_run + 8'd1 : 8'd0;
            hsync_run <= hsync ? hsync_run + 8'd1 : 8'd0;
        end
    end

    //////////////////////////////
    // line shape

    de_hsync_apart: assert property (@(posedge reset_clock) disable iff (reset_dc)
        !(de && hsync))
        else begin
            fail_count++;
            $error("de and hsync high in the same cycle");
        end

    de_not_too_long: assert property (@(posedge reset_clock) disable iff (reset_dc)
        de |-> de_run < 8'(`LINE_WIDTH))
        else begin
            fail_count++;
            $error("de stays high past the line width");
        end

    de_full_line: assert property (@(posedge reset_clock) disable iff (reset_dc)
        $fell(de) |-> de_run == 8'(`LINE_WIDTH))
        else begin
            fail_count++;
            $error("de ended before the line width");
        end

    hsync_width: assert property (@(posedge reset_clock) disable iff (reset_dc)
        $fell(hsync) |-> hsync_run == 8'(`OUT_HSYNC))
        else begin
            fail_count++;
            $error("hsync pulse has the wrong width");
        end

endmodule

bind hdmi_line_output dcxplus_asserts u_out_asserts (
    .reset_clock (reset_clock),
    .reset_dc    (reset_dc),
    .hsync       (hsync),
    .de          (de)
);

//--- dcxplus_checker.sv
`include "dcxplus_config.svh"

module dcxplus_checker import dcxplus_pkg::*; #(
    parameter int FRAME_LINES = 6,
    parameter int TOTAL_LINES = 18
) (
    input logic       reset_clock,
    input logic       reset_dc,
    input logic       hsync,
    input logic       vsync,
    input logic       de,
    input rgb_pixel_t video,
    input logic       dc_nreset_low
);

    timeunit 1ns;
    timeprecision 100ps;

    int   check_count    = 0;
    int   error_count    = 0;
    int   out_line_count = 0;
    int   pixel_index    = 0;
    int   hsync_len      = 0;
    int   porch_len      = 0;
    int   release_edges  = 0;
    logic prev_hsync     = 1'b0;
    logic prev_de        = 1'b0;

    task automatic compare_value(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
                     test_name, expected, actual, $time);
        end
    endtask

    task automatic check_blank(input string test_name);
        compare_value({test_name, " hsync"}, 0, {31'd0, hsync});
        compare_value({test_name, " vsync"}, 0, {31'd0, vsync});
        compare_value({test_name, " de"}, 0, {31'd0, de});
        compare_value({test_name, " video"}, 0, {8'h00, video});
    endtask

    //////////////////////////////
    // output line tracking

    task automatic check_line_timing();
        int   line_pair;
        logic frame_start;
        line_pair = out_line_count / 2;
        if (de) begin
            if (line_pair < TOTAL_LINES && pixel_index < `LINE_WIDTH) begin
                compare_value("doubled pixel",
                              {8'h00, tb_dcxplus.expected_pixel(line_pair, pixel_index)},
                              {8'h00, video});
            end else begin
                error_count++;
                $display("output line %0d carries pixels with no matching input", out_line_count);
            end
            pixel_index++;
        end else if (prev_de) begin
            compare_value("de length", `LINE_WIDTH, pixel_index);
            pixel_index = 0;
            out_line_count++;
        end
        if (hsync) begin
            hsync_len++;
            porch_len = 0;
        end else begin
            if (prev_hsync) begin
                compare_value("hsync length", `OUT_HSYNC, hsync_len);
                hsync_len = 0;
            end
            if (!de) begin
                porch_len++;
            end
        end
        if (de && !prev_de) begin
            compare_value("back porch", `OUT_HBACK, porch_len);
        end
        // pair index after a finished line, so a late vsync shows up
        line_pair   = out_line_count / 2;
        frame_start = (line_pair % FRAME_LINES) == 0;
        if (vsync || de) begin
            compare_value("frame vsync", {31'd0, frame_start}, {31'd0, vsync});
        end
    endtask

    // outputs settle after the rising edge, sample them in the low phase
    always @(negedge reset_clock) begin
        if (reset_dc) begin
            release_edges = 0;
            pixel_index   = 0;
            hsync_len     = 0;
            porch_len     = 0;
            compare_value("console reset held", 1, {31'd0, dc_nreset_low});
            check_blank("reset state");
        end else begin
            compare_value("console reset release",
                          {31'd0, release_edges < `DC_RESET_CYCLES}, {31'd0, dc_nreset_low});
            if (release_edges < 8) begin
                check_blank("after reset");
            end
            release_edges++;
            check_line_timing();
        end
        prev_hsync = hsync;
        prev_de    = de;
    end

endmodule

//--- dcxplus_config.svh
`ifndef DCXPLUS_CONFIG_SVH
`define DCXPLUS_CONFIG_SVH

//////////////////////////////
// line buffer geometry

// pixels stored and played back per line
`define LINE_WIDTH 32
// address width of one bank, must cover LINE_WIDTH
`define BUF_ADDR_W 5

//////////////////////////////
// output line timing, in cycles

`define OUT_HFRONT 4
`define OUT_HSYNC 4
`define OUT_HBACK 4

// console reset hold, short value for simulation
`define DC_RESET_CYCLES 64

`endif

//--- dcxplus_pkg.sv
package dcxplus_pkg;

    //////////////////////////////
    // video types

    // x or y position inside a frame
    typedef logic [11:0] line_coord_t;

    // 24-bit output pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_pixel_t;

endpackage

//--- dcxplus_top.sv
`include "dcxplus_config.svh"

module dcxplus_top import dcxplus_pkg::*; (
    input  logic        reset_clock,
    input  logic        reset_dc,
    input  logic        hsync_n,
    input  logic        vsync_n,
    input  logic [11:0] dc_data,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output rgb_pixel_t  video,
    output logic        dc_nreset_low
);

    // input side to buffer
    logic        pixel_valid;
    rgb_pixel_t  pixel;
    line_coord_t pixel_x;
    logic        line_done;
    line_coord_t line_y;

    // buffer to output side
    logic [`BUF_ADDR_W-1:0] rd_addr;
    rgb_pixel_t             rd_pixel;
    logic                   line_ready;
    line_coord_t            ready_y;

    //////////////////////////////
    // video path

    dc_video_input u_video_input (
        .reset_clock (reset_clock),
        .reset_dc    (reset_dc),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .dc_data     (dc_data),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_x     (pixel_x),
        .pixel_y     (),
        .line_done   (line_done),
        .line_y      (line_y)
    );

    line_doubler_buffer u_line_buffer (
        .reset_clock (reset_clock),
        .reset_dc    (reset_dc),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_x     (pixel_x),
        .line_done   (line_done),
        .line_y      (line_y),
        .rd_addr     (rd_addr),
        .rd_pixel    (rd_pixel),
        .line_ready  (line_ready),
        .ready_y     (ready_y)
    );

    hdmi_line_output u_line_output (
        .reset_clock (reset_clock),
        .reset_dc    (reset_dc),
        .line_ready  (line_ready),
        .ready_y     (ready_y),
        .rd_pixel    (rd_pixel),
        .rd_addr     (rd_addr),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .video       (video)
    );

    //////////////////////////////
    // console reset

    dc_reset_hold u_reset_hold (
        .reset_clock   (reset_clock),
        .reset_dc      (reset_dc),
        .dc_nreset_low (dc_nreset_low)
    );

endmodule

//--- hdmi_line_output.sv
`include "dcxplus_config.svh"

module hdmi_line_output import dcxplus_pkg::*; (
    input  logic                   reset_clock,
    input  logic                   reset_dc,
    input  logic                   line_ready,
    input  line_coord_t            ready_y,
    input  rgb_pixel_t             rd_pixel,
    output logic [`BUF_ADDR_W-1:0] rd_addr,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de,
    output rgb_pixel_t             video
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FRONT,
        ST_SYNC,
        ST_BACK,
        ST_ACTIVE
    } out_state_t;

    // last count of each phase
    localparam line_coord_t FRONT_LAST  = line_coord_t'(`OUT_HFRONT - 1);
    localparam line_coord_t SYNC_LAST   = line_coord_t'(`OUT_HSYNC - 1);
    localparam line_coord_t BACK_LAST   = line_coord_t'(`OUT_HBACK - 1);
    localparam line_coord_t ACTIVE_LAST = line_coord_t'(`LINE_WIDTH - 1);
    // buffer read plus output register, two cycles before de
    localparam line_coord_t FETCH_START = line_coord_t'(`OUT_HBACK - 2);

    out_state_t  state;
    line_coord_t cycle_cnt;
    logic        second_copy;
    logic        fetch_next;

    assign fetch_next = (state == ST_ACTIVE) ||
                        ((state == ST_BACK) && (cycle_cnt >= FETCH_START));

    //////////////////////////////
    // read address lookahead

    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            rd_addr <= '0;
        end else if (state == ST_FRONT) begin
            rd_addr <= '0;
        end else if (fetch_next) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    //////////////////////////////
    // line timing FSM

    // outputs are set on the transitions so they line up with the state
    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            state       <= ST_IDLE;
            cycle_cnt   <= '0;
            second_copy <= 1'b0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            de          <= 1'b0;
            video       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (line_ready) begin
                        state       <= ST_FRONT;
                        cycle_cnt   <= '0;
                        second_copy <= 1'b0;
                        // frame sync spans both copies of line 0
                        vsync       <= (ready_y == '0);
                    end
                end
                ST_FRONT: begin
                    if (cycle_cnt == FRONT_LAST) begin
                        state     <= ST_SYNC;
                        cycle_cnt <= '0;
                        hsync     <= 1'b1;
                    end else begin
                        cycle_cnt <= cycle_cnt + line_coord_t'(1);
                    end
                end
                ST_SYNC: begin
                    if (cycle_cnt == SYNC_LAST) begin
                        state     <= ST_BACK;
                        cycle_cnt <= '0;
                        hsync     <= 1'b0;
                    end else begin
                        cycle_cnt <= cycle_cnt + line_coord_t'(1);
                    end
                end
                ST_BACK: begin
                    if (cycle_cnt == BACK_LAST) begin
                        state     <= ST_ACTIVE;
                        cycle_cnt <= '0;
                        de        <= 1'b1;
                        video     <= rd_pixel;
                    end else begin
                        cycle_cnt <= cycle_cnt + line_coord_t'(1);
                    end
                end
                ST_ACTIVE: begin
                    if (cycle_cnt == ACTIVE_LAST) begin
                        de        <= 1'b0;
                        video     <= '0;
                        cycle_cnt <= '0;
                        if (second_copy) begin
                            state <= ST_IDLE;
                            vsync <= 1'b0;
                        end else begin
                            // replay the same bank once more
                            state       <= ST_FRONT;
                            second_copy <= 1'b1;
                        end
                    end else begin
                        video     <= rd_pixel;
                        cycle_cnt <= cycle_cnt + line_coord_t'(1);
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- line_doubler_buffer.sv
`include "dcxplus_config.svh"

module line_doubler_buffer import dcxplus_pkg::*; (
    input  logic                   reset_clock,
    input  logic                   reset_dc,
    input  logic                   pixel_valid,
    input  rgb_pixel_t             pixel,
    input  line_coord_t            pixel_x,
    input  logic                   line_done,
    input  line_coord_t            line_y,
    input  logic [`BUF_ADDR_W-1:0] rd_addr,
    output rgb_pixel_t             rd_pixel,
    output logic                   line_ready,
    output line_coord_t            ready_y
);

    // bank 0 and bank 1, one line each
    rgb_pixel_t mem [2][`LINE_WIDTH];

    logic wr_bank;
    logic rd_bank;
    logic wr_en;

    // reader always sits on the bank finished last
    assign rd_bank = ~wr_bank;

    // anything past the stored width is dropped
    assign wr_en = pixel_valid && (pixel_x < line_coord_t'(`LINE_WIDTH));

    //////////////////////////////
    // bank select and line hand-off

    always_ff @(posedge reset_clock or posedge reset_dc) begin
        if (reset_dc) begin
            wr_bank    <= 1'b0;
            line_ready <= 1'b0;
            ready_y    <= '0;
        end else begin
            line_ready <= line_done;
            if (line_done) begin
                wr_bank <= ~wr_bank;
                ready_y <= line_y;
            end
        end
    end

    //////////////////////////////
    // memory access

    always_ff @(posedge reset_clock) begin
        if (wr_en) begin
            mem[wr_bank][pixel_x[`BUF_ADDR_W-1:0]] <= pixel;
        end
    end

    // one cycle read latency
    always_ff @(posedge reset_clock) begin
        rd_pixel <= mem[rd_bank][rd_addr];
    end

endmodule

//--- tb.f
+incdir+.
dcxplus_pkg.sv
dc_video_input.sv
line_doubler_buffer.sv
hdmi_line_output.sv
dc_reset_hold.sv
dcxplus_top.sv
dcxplus_asserts.sv
dcxplus_checker.sv
tb_dcxplus.sv

//--- tb_dcxplus.sv
`include "dcxplus_config.svh"

module tb_dcxplus import dcxplus_pkg::*; #(
    parameter int SEED = 27
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_LINES   = 6;
    localparam int FRAMES        = 3;
    localparam int TOTAL_LINES   = FRAME_LINES * FRAMES;
    localparam int HBLANK_CYCLES = 40;
    localparam int VSYNC_CYCLES  = 4;
    localparam int DRAIN_TIMEOUT = 1000;

    logic        reset_clock;
    logic        reset_dc;
    logic        hsync_n;
    logic        vsync_n;
    logic [11:0] dc_data;
    logic        hsync;
    logic        vsync;
    logic        de;
    rgb_pixel_t  video;
    logic        dc_nreset_low;

    integer     seed;
    bit         timed_out;
    int         total_errors;
    // every pixel sent, indexed by line count since the first frame
    rgb_pixel_t line_pixels [TOTAL_LINES][`LINE_WIDTH];

    always #10 reset_clock = ~reset_clock;

    dcxplus_top dut (
        .reset_clock   (reset_clock),
        .reset_dc      (reset_dc),
        .hsync_n       (hsync_n),
        .vsync_n       (vsync_n),
        .dc_data       (dc_data),
        .hsync         (hsync),
        .vsync         (vsync),
        .de            (de),
        .video         (video),
        .dc_nreset_low (dc_nreset_low)
    );

    dcxplus_checker #(
        .FRAME_LINES (FRAME_LINES),
        .TOTAL_LINES (TOTAL_LINES)
    ) u_checker (
        .reset_clock   (reset_clock),
        .reset_dc      (reset_dc),
        .hsync         (hsync),
        .vsync         (vsync),
        .de            (de),
        .video         (video),
        .dc_nreset_low (dc_nreset_low)
    );

    // what the k-th de cycle of a doubled line must carry
    function automatic rgb_pixel_t expected_pixel(input int line_num, input int pix_index);
        return line_pixels[line_num][pix_index];
    endfunction

    //////////////////////////////
    // stimulus

    task automatic send_frame_start();
        @(posedge reset_clock);
        vsync_n <= 1'b0;
        repeat (VSYNC_CYCLES) @(posedge reset_clock);
        vsync_n <= 1'b1;
    endtask

    // two phases per pixel, then horizontal blanking
    task automatic send_line(input int line_num);
        logic [31:0] rnd;
        rgb_pixel_t  pix;
        for (int i = 0; i < `LINE_WIDTH; i++) begin
            rnd = $random(seed);
            pix = rnd[23:0];
            line_pixels[line_num][i] = pix;
            @(posedge reset_clock);
            hsync_n <= 1'b1;
            dc_data <= {pix.red, pix.green[7:4]};
            @(posedge reset_clock);
            dc_data <= {pix.green[3:0], pix.blue};
        end
        @(posedge reset_clock);
        hsync_n <= 1'b0;
        dc_data <= '0;
        repeat (HBLANK_CYCLES - 1) @(posedge reset_clock);
    endtask

    task automatic wait_output_lines(input int target, output bit expired);
        int cycles;
        cycles = 0;
        while (u_checker.out_line_count < target && cycles < DRAIN_TIMEOUT) begin
            @(posedge reset_clock);
            cycles++;
        end
        expired = (u_checker.out_line_count < target);
    endtask

    initial begin
        reset_clock  = 1'b0;
        reset_dc     = 1'b1;
        hsync_n      = 1'b0;
        vsync_n      = 1'b1;
        dc_data      = '0;
        seed         = SEED;
        total_errors = 0;
        repeat (8) @(posedge reset_clock);
        reset_dc <= 1'b0;
        // let the sync registers settle before the first vsync edge
        repeat (4) @(posedge reset_clock);
        for (int f = 0; f < FRAMES; f++) begin
            send_frame_start();
            for (int l = 0; l < FRAME_LINES; l++) begin
                send_line(f * FRAME_LINES + l);
            end
        end
        wait_output_lines(2 * TOTAL_LINES, timed_out);
        repeat (4) @(posedge reset_clock);
        if (timed_out) begin
            $display("timeout: only %0d of %0d output lines came out",
                     u_checker.out_line_count, 2 * TOTAL_LINES);
        end
        total_errors = u_checker.error_count + dut.u_line_output.u_out_asserts.fail_count;
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 u_checker.check_count, u_checker.error_count,
                 dut.u_line_output.u_out_asserts.fail_count);
        if (timed_out || total_errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule
